/* tb.f */
design/cache_geom_pkg.sv
design/mem_op_pkg.sv
design/cache_ifs.sv
design/tag_store.sv
design/line_store.sv
design/bus_port.sv
design/cache_ctrl.sv
design/dcache_top.sv
verif/tb_dcache.sv

/* Makefile */
# Verilator build for the data cache testbench
TOP = tb_dcache

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing -f tb.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

/* verif/tb_dcache.sv */
// testbench for the 4-way write-back data cache
// table-driven loads and stores, bus memory model with random stalls
`timescale 1ns/1ps

module tb_dcache;
  import cache_geom_pkg::*;
  import mem_op_pkg::*;

  typedef struct packed {
    mem_op_t op;
    logic [addr_w-1:0] addr;
    logic [bus_data_w-1:0] wdata;
    logic [bus_data_w-1:0] exp;
    logic quiet;
  } entry_t;

  logic clk;
  logic reset;
  logic req;
  mem_op_t op;
  logic [addr_w-1:0] addr;
  logic [bus_data_w-1:0] wdata;
  logic busy;
  logic done;
  logic [bus_data_w-1:0] rdata;
  logic bus_reqcyc;
  logic bus_reqack;
  logic [bus_data_w-1:0] bus_req;
  logic [bus_tag_w-1:0] bus_reqtag;
  logic bus_respcyc;
  logic bus_respack;
  logic [bus_data_w-1:0] bus_resp;
  logic [bus_tag_w-1:0] bus_resptag;

  integer seed = 32'h15fa;
  entry_t tbl[$];
  logic table_ready = 1'b0;
  // bus memory and the load/store view by doubleword address
  logic [63:0] mem [logic [28:0]];
  logic [63:0] shadow [logic [28:0]];
  logic [addr_w-1:0] cur_addr;
  int req_beats = 0;
  int wb_count = 0;

  dcache_top u_dcache_top (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // untouched memory holds line address xor beat index shifted by 8
  function automatic logic [63:0] init_dw(logic [addr_w-1:0] a);
    return {32'h0, a[31:6], 6'h0} ^ {53'h0, a[5:3], 8'h0};
  endfunction

  function automatic logic [63:0] mem_read(logic [addr_w-1:0] a);
    return mem.exists(a[31:3]) ? mem[a[31:3]] : init_dw(a);
  endfunction

  function automatic logic [63:0] shadow_read(logic [addr_w-1:0] a);
    return shadow.exists(a[31:3]) ? shadow[a[31:3]] : init_dw(a);
  endfunction

  // little endian slice, then sign or zero extension
  function automatic logic [63:0] expected_load(mem_op_t o, logic [addr_w-1:0] a);
    logic [63:0] s;
    s = shadow_read(a) >> {a[2:0], 3'b000};
    case (o)
      LD:      return s;
      LW:      return {{32{s[31]}}, s[31:0]};
      LH:      return {{48{s[15]}}, s[15:0]};
      LB:      return {{56{s[7]}}, s[7:0]};
      LWU:     return {32'h0, s[31:0]};
      LHU:     return {48'h0, s[15:0]};
      LBU:     return {56'h0, s[7:0]};
      default: return '0;
    endcase
  endfunction

  function automatic void store_shadow(mem_op_t o, logic [addr_w-1:0] a, logic [63:0] d);
    logic [63:0] mask;
    logic [5:0] sh;
    sh = {a[2:0], 3'b000};
    case (o)
      SD:      mask = '1;
      SW:      mask = 64'hffff_ffff;
      SH:      mask = 64'hffff;
      SB:      mask = 64'hff;
      default: mask = '0;
    endcase
    shadow[a[31:3]] = (shadow_read(a) & ~(mask << sh)) | ((d & mask) << sh);
  endfunction

  function automatic void add_entry(mem_op_t o, logic [addr_w-1:0] a, logic [63:0] d, logic q);
    tbl.push_back('{op: o, addr: a, wdata: d, exp: '0, quiet: q});
  endfunction

  function automatic void build_table();
    // refill, then every load size on the same line
    add_entry(LD, 32'h8000_1240, 64'h0, 1'b0);
    add_entry(LD, 32'h8000_1248, 64'h0, 1'b1);
    add_entry(LW, 32'h8000_1240, 64'h0, 1'b1);
    add_entry(LWU, 32'h8000_1240, 64'h0, 1'b1);
    add_entry(LH, 32'h8000_1242, 64'h0, 1'b1);
    add_entry(LHU, 32'h8000_1242, 64'h0, 1'b1);
    add_entry(LB, 32'h8000_1243, 64'h0, 1'b1);
    add_entry(LBU, 32'h8000_1243, 64'h0, 1'b1);
    add_entry(LW, 32'h8000_1244, 64'h0, 1'b1);
    // store miss allocates, each size read back as a doubleword
    add_entry(SD, 32'h0000_2100, 64'hfedc_ba98_7654_3210, 1'b0);
    add_entry(LD, 32'h0000_2100, 64'h0, 1'b1);
    add_entry(SW, 32'h0000_210c, 64'h1111_1111_8765_4321, 1'b1);
    add_entry(LD, 32'h0000_2108, 64'h0, 1'b1);
    add_entry(SH, 32'h0000_211a, 64'haaaa_bbbb_cccc_f00d, 1'b1);
    add_entry(LD, 32'h0000_2118, 64'h0, 1'b1);
    add_entry(SB, 32'h0000_213f, 64'h0123_4567_89ab_cda5, 1'b1);
    add_entry(LD, 32'h0000_2138, 64'h0, 1'b1);
    add_entry(LB, 32'h0000_213f, 64'h0, 1'b1);
    add_entry(LH, 32'h0000_211a, 64'h0, 1'b1);
    // five dirty lines in set 1, then read back through the write-backs
    add_entry(SD, 32'h0000_3040, 64'h0a0a_0b0b_0c0c_0d0d, 1'b0);
    add_entry(SD, 32'h0000_3840, 64'h1234_0000_5678_0000, 1'b0);
    add_entry(SW, 32'h0000_4044, 64'h0000_0000_dead_beef, 1'b0);
    add_entry(SH, 32'h0000_4842, 64'h0000_0000_0000_c0de, 1'b0);
    add_entry(SB, 32'h0000_5047, 64'h0000_0000_0000_0099, 1'b0);
    add_entry(LD, 32'h0000_3040, 64'h0, 1'b0);
    add_entry(LD, 32'h0000_3840, 64'h0, 1'b0);
    add_entry(LW, 32'h0000_4044, 64'h0, 1'b0);
    add_entry(LH, 32'h0000_4842, 64'h0, 1'b0);
    add_entry(LB, 32'h0000_5047, 64'h0, 1'b0);
    add_entry(LD, 32'h8000_1278, 64'h0, 1'b1);
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_word(input string name, input logic [bus_data_w-1:0] exp,
                            input logic [bus_data_w-1:0] act);
    if (act !== exp)
      fail_run($sformatf("error: %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_line(input string name, input line_t exp, input line_t act);
    if (act !== exp)
      fail_run($sformatf("error: %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
      fail_run($sformatf("error: %s expected %b actual %b", name, exp, act));
  endtask

  // one request beat with the ack stretched at random
  task automatic take_beat(output logic [bus_data_w-1:0] data,
                           output logic [bus_tag_w-1:0] tag);
    logic taken;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      bus_reqack = bus_reqcyc && (($random(seed) & 3) != 0);
      taken = bus_reqack;
    end
    data = bus_req;
    tag = bus_reqtag;
    req_beats++;
  endtask

  // eight response beats with random gaps
  task automatic send_line(input logic [addr_w-1:0] line_addr);
    int gap;
    @(negedge clk);
    bus_reqack = 1'b0;
    for (int i = 0; i < beats_per_line; i++) begin
      gap = $random(seed) & 3;
      repeat (gap) @(negedge clk);
      bus_respcyc = 1'b1;
      bus_resptag = tag_read;
      bus_resp = mem_read(line_addr + 32'(i * 8));
      @(negedge clk);
      bus_respcyc = 1'b0;
      bus_resptag = tag_none;
      check_flag("respack after a response beat", 1'b1, bus_respack);
    end
  endtask

  initial begin : memory_model
    logic [bus_data_w-1:0] data;
    logic [bus_tag_w-1:0] tag;
    logic [addr_w-1:0] line_addr;
    logic [addr_w-1:0] beat_addr;
    line_t got;
    line_t want;
    bus_reqack = 1'b0;
    bus_respcyc = 1'b0;
    bus_resp = '0;
    bus_resptag = tag_none;
    forever begin
      take_beat(data, tag);
      line_addr = data[addr_w-1:0];
      if (tag == tag_write) begin
        check_word("write-back address alignment", 64'h0, data & 64'h3f);
        for (int i = 0; i < beats_per_line; i++) begin
          take_beat(data, tag);
          check_flag("write-back beat tag", 1'b1, tag == tag_write);
          beat_addr = line_addr + 32'(i * 8);
          got.dw[i] = data;
          want.dw[i] = shadow_read(beat_addr);
          mem[beat_addr[31:3]] = data;
        end
        check_line($sformatf("write-back of line %h", line_addr), want, got);
        wb_count++;
      end else if (tag == tag_read) begin
        // refill must target the line of the pending request
        check_word("refill address", {32'h0, cur_addr[31:6], 6'h0}, data);
        send_line(line_addr);
      end else begin
        fail_run($sformatf("bus request beat carried unknown tag %h", tag));
      end
    end
  end

  task automatic run_entry(input int i);
    entry_t e;
    int beats_before;
    logic saw_busy;
    e = tbl[i];
    beats_before = req_beats;
    saw_busy = 1'b0;
    @(negedge clk);
    cur_addr = e.addr;
    req = 1'b1;
    op = e.op;
    addr = e.addr;
    wdata = e.wdata;
    do begin
      @(negedge clk);
      saw_busy = saw_busy | busy;
    end while (!done);
    req = 1'b0;
    check_flag("busy low with done", 1'b0, busy);
    if (e.op inside {SD, SW, SH, SB}) begin
      store_shadow(e.op, e.addr, e.wdata);
    end else begin
      e.exp = expected_load(e.op, e.addr);
      tbl[i] = e;
      check_word($sformatf("entry %0d %s @%h", i, e.op.name(), e.addr), e.exp, rdata);
    end
    // hits stay off the bus and never raise busy
    if (e.quiet) begin
      check_word($sformatf("entry %0d bus beats", i), 64'(beats_before), 64'(req_beats));
      check_flag($sformatf("entry %0d busy on a hit", i), 1'b0, saw_busy);
    end
  endtask

  initial begin : watchdog
    wait (table_ready);
    repeat (tbl.size() * 200 + 10) @(posedge clk);
    fail_run($sformatf("timeout: run did not finish in %0d cycles", tbl.size() * 200 + 10));
  end

  initial begin : stimulus
    reset = 1'b0;
    req = 1'b0;
    op = LD;
    addr = '0;
    wdata = '0;
    build_table();
    table_ready = 1'b1;
    repeat (10) @(negedge clk);
    reset = 1'b1;
    @(negedge clk);
    check_flag("busy after reset", 1'b0, busy);
    check_flag("done after reset", 1'b0, done);
    check_flag("bus_reqcyc after reset", 1'b0, bus_reqcyc);
    check_flag("bus_respack after reset", 1'b0, bus_respack);
    for (int i = 0; i < tbl.size(); i++) begin
      run_entry(i);
    end
    check_flag("dirty victim written back", 1'b1, wb_count != 0);
    $display("Finished with no errors");
    $finish;
  end

endmodule

/* design/dcache_top.sv */
// 8 KB 4-way write-back data cache for a 64-bit load/store unit
// the lsu keeps op, addr and wdata steady until done
`timescale 1ns/1ps

module dcache_top (
  input  logic clk,
  input  logic reset,
  input  logic req,
  input  mem_op_pkg::mem_op_t op,
  input  logic [cache_geom_pkg::addr_w-1:0] addr,
  input  logic [mem_op_pkg::bus_data_w-1:0] wdata,
  output logic busy,
  output logic done,
  output logic [mem_op_pkg::bus_data_w-1:0] rdata,
  output logic bus_reqcyc,
  input  logic bus_reqack,
  output logic [mem_op_pkg::bus_data_w-1:0] bus_req,
  output logic [mem_op_pkg::bus_tag_w-1:0] bus_reqtag,
  input  logic bus_respcyc,
  output logic bus_respack,
  input  logic [mem_op_pkg::bus_data_w-1:0] bus_resp,
  input  logic [mem_op_pkg::bus_tag_w-1:0] bus_resptag
);

  logic store_wr;
  logic line_fill;

  lookup_if lookup_bus ();
  xfer_if xfer_bus ();

  cache_ctrl u_cache_ctrl (
    .clk(clk), .reset(reset), .req(req), .op(op), .addr(addr),
    .busy(busy), .done(done), .lookup(lookup_bus.ctrl), .xfer(xfer_bus.ctrl),
    .store_wr(store_wr), .line_fill(line_fill)
  );

  tag_store u_tag_store (.clk(clk), .reset(reset), .lookup(lookup_bus.store));

  // hit_way doubles as the victim way while the controller is not looking up
  line_store u_line_store (
    .clk(clk), .way(lookup_bus.hit_way), .index(lookup_bus.addr.index),
    .offset(lookup_bus.addr.offset), .op(op), .wdata(wdata),
    .store_wr(store_wr), .line_fill(line_fill), .fill_line(xfer_bus.fill_line),
    .rdata(rdata), .victim_line(xfer_bus.evict_line)
  );

  bus_port u_bus_port (
    .clk(clk), .reset(reset), .xfer(xfer_bus.port),
    .bus_reqcyc(bus_reqcyc), .bus_reqack(bus_reqack), .bus_req(bus_req),
    .bus_reqtag(bus_reqtag), .bus_respcyc(bus_respcyc), .bus_respack(bus_respack),
    .bus_resp(bus_resp), .bus_resptag(bus_resptag)
  );

endmodule

/* design/cache_ctrl.sv */
// data cache controller
// hit in one cycle, miss runs write-back, refill, fill, retry
`timescale 1ns/1ps

module cache_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req,
  input  mem_op_pkg::mem_op_t op,
  input  cache_geom_pkg::cache_addr_t addr,
  output logic busy,
  output logic done,
  lookup_if.ctrl lookup,
  xfer_if.ctrl xfer,
  output logic store_wr,
  output logic line_fill
);
  import cache_geom_pkg::*;
  import mem_op_pkg::*;

  typedef enum logic [2:0] {
    s_idle, s_writeback, s_refill, s_fill, s_retry
  } ctrl_state_t;

  ctrl_state_t state;
  cache_addr_t req_addr;
  mem_op_t req_op;
  mem_op_t cur_op;
  logic is_store;

  assign busy = (state != s_idle);

  // live request while idle, held copy during a miss
  assign lookup.addr = (state == s_idle) ? addr : req_addr;
  assign cur_op = (state == s_idle) ? op : req_op;
  assign is_store = cur_op inside {SD, SW, SH, SB};
  assign lookup.lookup = ((state == s_idle) && req) || (state == s_retry);

  // hit is already qualified by lookup
  assign store_wr = lookup.hit && is_store;
  assign line_fill = (state == s_fill);
  assign lookup.fill = line_fill;
  assign lookup.mark_dirty = store_wr || (line_fill && is_store);

  // both transfers are line aligned
  assign xfer.evict_addr = '{tag: lookup.victim_tag, index: req_addr.index, offset: '0};
  assign xfer.fill_addr = '{tag: req_addr.tag, index: req_addr.index, offset: '0};

  always_ff @(posedge clk) begin
    if (!reset) begin
      state <= s_idle;
      done <= 1'b0;
      xfer.start_evict <= 1'b0;
      xfer.start_fill <= 1'b0;
    end else begin
      done <= 1'b0;
      xfer.start_evict <= 1'b0;
      xfer.start_fill <= 1'b0;
      case (state)
        s_idle, s_retry: begin
          if (lookup.hit) begin
            done <= 1'b1;
            state <= s_idle;
          end else if (lookup.lookup) begin
            // dirty victim goes out before the refill
            xfer.start_evict <= lookup.victim_dirty;
            xfer.start_fill <= !lookup.victim_dirty;
            state <= lookup.victim_dirty ? s_writeback : s_refill;
          end
        end
        s_writeback: begin
          if (xfer.xfer_done) begin
            xfer.start_fill <= 1'b1;
            state <= s_refill;
          end
        end
        s_refill: begin
          if (xfer.xfer_done) begin
            state <= s_fill;
          end
        end
        s_fill:  state <= s_retry;
        default: state <= s_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == s_idle) && req) begin
      req_addr <= addr;
      req_op <= op;
    end
  end

endmodule

/* design/bus_port.sv */
// memory bus side of the data cache
// serialises write-backs, issues refill reads, collects 8 beats
`timescale 1ns/1ps

module bus_port (
  input  logic clk,
  input  logic reset,
  xfer_if.port xfer,
  output logic bus_reqcyc,
  input  logic bus_reqack,
  output logic [mem_op_pkg::bus_data_w-1:0] bus_req,
  output logic [mem_op_pkg::bus_tag_w-1:0] bus_reqtag,
  input  logic bus_respcyc,
  output logic bus_respack,
  input  logic [mem_op_pkg::bus_data_w-1:0] bus_resp,
  input  logic [mem_op_pkg::bus_tag_w-1:0] bus_resptag
);
  import cache_geom_pkg::*;
  import mem_op_pkg::*;

  typedef enum logic [2:0] {
    p_idle, p_wb_addr, p_wb_data, p_rd_addr, p_rd_data
  } port_state_t;

  port_state_t state;
  logic [beat_w-1:0] beat;
  logic [beat_w-1:0] next_beat;
  logic last_beat;

  assign next_beat = beat + 1'b1;
  assign last_beat = (beat == beat_w'(beats_per_line - 1));

  always_ff @(posedge clk) begin
    if (!reset) begin
      state <= p_idle;
      beat <= '0;
      bus_reqcyc <= 1'b0;
      bus_reqtag <= tag_none;
      bus_respack <= 1'b0;
      xfer.xfer_done <= 1'b0;
    end else begin
      bus_respack <= 1'b0;
      xfer.xfer_done <= 1'b0;
      case (state)
        p_idle: begin
          // address beat one cycle after the start pulse
          if (xfer.start_evict) begin
            bus_reqcyc <= 1'b1;
            bus_reqtag <= tag_write;
            bus_req <= {{(bus_data_w - addr_w){1'b0}}, xfer.evict_addr};
            state <= p_wb_addr;
          end else if (xfer.start_fill) begin
            bus_reqcyc <= 1'b1;
            bus_reqtag <= tag_read;
            bus_req <= {{(bus_data_w - addr_w){1'b0}}, xfer.fill_addr};
            state <= p_rd_addr;
          end
        end
        p_wb_addr: begin
          if (bus_reqack) begin
            beat <= '0;
            bus_req <= xfer.evict_line.dw[0];
            state <= p_wb_data;
          end
        end
        p_wb_data: begin
          // each beat held until acked, lowest doubleword first
          if (bus_reqack) begin
            if (last_beat) begin
              bus_reqcyc <= 1'b0;
              bus_reqtag <= tag_none;
              xfer.xfer_done <= 1'b1;
              state <= p_idle;
            end else begin
              beat <= next_beat;
              bus_req <= xfer.evict_line.dw[next_beat];
            end
          end
        end
        p_rd_addr: begin
          if (bus_reqack) begin
            bus_reqcyc <= 1'b0;
            bus_reqtag <= tag_none;
            beat <= '0;
            state <= p_rd_data;
          end
        end
        p_rd_data: begin
          // every respcyc cycle is one beat, gaps allowed
          if (bus_respcyc && (bus_resptag == tag_read)) begin
            xfer.fill_line.dw[beat] <= bus_resp;
            bus_respack <= 1'b1;
            beat <= next_beat;
            if (last_beat) begin
              xfer.xfer_done <= 1'b1;
              state <= p_idle;
            end
          end
        end
        default: state <= p_idle;
      endcase
    end
  end

endmodule

/* design/line_store.sv */
// line data array of the data cache
// load slice with sign/zero extension, store merge by size
`timescale 1ns/1ps

module line_store (
  input  logic clk,
  input  cache_geom_pkg::way_t way,
  input  logic [cache_geom_pkg::index_w-1:0] index,
  input  logic [cache_geom_pkg::offset_w-1:0] offset,
  input  mem_op_pkg::mem_op_t op,
  input  logic [mem_op_pkg::bus_data_w-1:0] wdata,
  input  logic store_wr,
  input  logic line_fill,
  input  cache_geom_pkg::line_t fill_line,
  output logic [mem_op_pkg::bus_data_w-1:0] rdata,
  output cache_geom_pkg::line_t victim_line
);
  import cache_geom_pkg::*;
  import mem_op_pkg::*;

  line_t data [num_sets][num_ways];

  line_t cur;
  line_t merged;
  logic [63:0] dw_sel;
  logic [31:0] w_sel;
  logic [15:0] h_sel;
  logic [7:0] b_sel;
  logic [bus_data_w-1:0] load_val;

  assign cur = data[index][way];
  assign victim_line = cur;

  // same line, four views
  assign dw_sel = cur.dw[offset[offset_w-1:3]];
  assign w_sel = cur.w[offset[offset_w-1:2]];
  assign h_sel = cur.h[offset[offset_w-1:1]];
  assign b_sel = cur.b[offset];

  always_comb begin
    case (op)
      LD:      load_val = dw_sel;
      LW:      load_val = {{32{w_sel[31]}}, w_sel};
      LH:      load_val = {{48{h_sel[15]}}, h_sel};
      LB:      load_val = {{56{b_sel[7]}}, b_sel};
      LWU:     load_val = {32'b0, w_sel};
      LHU:     load_val = {48'b0, h_sel};
      LBU:     load_val = {56'b0, b_sel};
      default: load_val = '0;
    endcase
  end

  // store data lands in the low bits of wdata
  always_comb begin
    merged = cur;
    case (op)
      SD:      merged.dw[offset[offset_w-1:3]] = wdata;
      SW:      merged.w[offset[offset_w-1:2]] = wdata[31:0];
      SH:      merged.h[offset[offset_w-1:1]] = wdata[15:0];
      SB:      merged.b[offset] = wdata[7:0];
      default: merged = cur;
    endcase
  end

  always_ff @(posedge clk) begin
    if (line_fill) begin
      data[index][way] <= fill_line;
    end else if (store_wr) begin
      data[index][way] <= merged;
    end
    // captured on the edge that raises done
    rdata <= load_val;
  end

endmodule

/* design/tag_store.sv */
// tag, valid and dirty arrays of the data cache
// parallel 4-way compare, round-robin victim per set
`timescale 1ns/1ps

module tag_store (
  input logic clk,
  input logic reset,
  lookup_if.store lookup
);
  import cache_geom_pkg::*;

  logic [tag_w-1:0] tags [num_sets][num_ways];
  logic [num_ways-1:0] valid [num_sets];
  logic [num_ways-1:0] dirty [num_sets];
  way_t rr_ptr [num_sets];

  logic [index_w-1:0] idx;
  logic [num_ways-1:0] match;
  way_t match_way;

  assign idx = lookup.addr.index;

  // compare all ways at once
  always_comb begin
    match = '0;
    match_way = '0;
    for (int w = 0; w < num_ways; w++) begin
      match[w] = valid[idx][w] && (tags[idx][w] == lookup.addr.tag);
      if (match[w]) begin
        match_way = way_t'(w);
      end
    end
  end

  assign lookup.hit = lookup.lookup && (|match);
  // on a miss hit_way falls back to the victim, so the data array
  // follows the refill way without a mux in the controller
  assign lookup.hit_way = lookup.hit ? match_way : lookup.victim_way;
  assign lookup.victim_way = rr_ptr[idx];
  assign lookup.victim_dirty = valid[idx][lookup.victim_way] && dirty[idx][lookup.victim_way];
  assign lookup.victim_tag = tags[idx][lookup.victim_way];

  always_ff @(posedge clk) begin
    if (!reset) begin
      for (int s = 0; s < num_sets; s++) begin
        valid[s] <= '0;
        dirty[s] <= '0;
        rr_ptr[s] <= '0;
      end
    end else if (lookup.fill) begin
      // new line goes in at the victim, pointer moves on
      valid[idx][lookup.victim_way] <= 1'b1;
      dirty[idx][lookup.victim_way] <= lookup.mark_dirty;
      rr_ptr[idx] <= rr_ptr[idx] + 1'b1;
    end else if (lookup.mark_dirty) begin
      // store hit
      dirty[idx][lookup.hit_way] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (lookup.fill) begin
      tags[idx][lookup.victim_way] <= lookup.addr.tag;
    end
  end

endmodule

/* design/cache_ifs.sv */
// controller links to the tag store and to the bus port
`timescale 1ns/1ps

interface lookup_if;
  import cache_geom_pkg::*;

  cache_addr_t addr;
  logic lookup;
  logic fill;
  logic mark_dirty;
  logic hit;
  way_t hit_way;
  way_t victim_way;
  logic victim_dirty;
  logic [tag_w-1:0] victim_tag;

  modport ctrl (
    output addr, lookup, fill, mark_dirty,
    input  hit, hit_way, victim_way, victim_dirty, victim_tag
  );
  modport store (
    input  addr, lookup, fill, mark_dirty,
    output hit, hit_way, victim_way, victim_dirty, victim_tag
  );
endinterface

interface xfer_if;
  import cache_geom_pkg::*;

  logic start_evict;
  logic start_fill;
  cache_addr_t evict_addr;
  cache_addr_t fill_addr;
  // victim data comes straight off the line store
  line_t evict_line;
  logic xfer_done;
  line_t fill_line;

  modport ctrl (
    output start_evict, start_fill, evict_addr, fill_addr,
    input  xfer_done
  );
  modport port (
    input  start_evict, start_fill, evict_addr, fill_addr, evict_line,
    output xfer_done, fill_line
  );
endinterface

/* design/mem_op_pkg.sv */
// load/store operation codes and memory bus encodings
package mem_op_pkg;

  localparam int bus_data_w = 64;
  localparam int bus_tag_w = 4;

  // loads first, stores from SD upward
  typedef enum logic [3:0] {
    LD, LW, LH, LB, LWU, LHU, LBU,
    SD, SW, SH, SB
  } mem_op_t;

  // tag carried on both bus channels
  typedef enum logic [bus_tag_w-1:0] {
    tag_none  = 4'h0,
    tag_read  = 4'h1,
    tag_write = 4'h2
  } bus_tag_t;

endpackage

/* design/cache_geom_pkg.sv */
// data cache geometry
// 4-way, 32 sets of 64-byte lines, 32-bit addresses
package cache_geom_pkg;

  localparam int addr_w = 32;
  localparam int offset_w = 6;
  localparam int index_w = 5;
  localparam int tag_w = addr_w - index_w - offset_w;

  localparam int num_ways = 4;
  localparam int num_sets = 32;
  localparam int beats_per_line = 8;
  // counter width for one line of beats
  localparam int beat_w = 3;

  typedef logic [1:0] way_t;

  // address as seen by the tag and data arrays
  typedef struct packed {
    logic [tag_w-1:0] tag;
    logic [index_w-1:0] index;
    logic [offset_w-1:0] offset;
  } cache_addr_t;

  // one 512-bit line, picked apart by access size
  // element 0 is the lowest address in every view
  typedef union packed {
    logic [beats_per_line-1:0][63:0] dw;
    logic [15:0][31:0] w;
    logic [31:0][15:0] h;
    logic [63:0][7:0] b;
  } line_t;

endpackage
